// ==== logic/ice_pkg.sv ====
`default_nettype none

package ice_pkg;

	// Longest accepted frame payload
	localparam int MAX_PAYLOAD = 8;
	// Longest reply payload
	localparam int REPLY_BYTES = 4;
	// Requester 0 is the decoder NAK, 1 basics, 2 GPIO
	localparam int NUM_RESP = 3;

	// Frame type byte, ASCII command letters
	typedef enum logic [7:0] {
		CMD_VERSION    = 8'h56,
		CMD_SET_WRITE  = 8'h53,
		CMD_SET_READ   = 8'h73,
		CMD_GPIO_WRITE = 8'h47,
		CMD_GPIO_READ  = 8'h67
	} ice_cmd_e;

	// First byte of every reply
	typedef enum logic [7:0] {
		REPLY_ACK = 8'h00,
		REPLY_NAK = 8'h01
	} reply_kind_e;

	// Master bus, driven by the decoder only
	typedef struct packed {
		logic       frame_valid;
		logic       data_valid;
		logic [7:0] addr;
		logic [7:0] data;
	} ma_bus_t;

	// Header fields of the current frame
	typedef struct packed {
		logic [7:0] evt_id;
		logic [7:0] len;
		logic       frame_end;
	} ma_frame_t;

	// Reply descriptor, payload[0] goes out first
	typedef struct packed {
		reply_kind_e                 kind;
		logic [7:0]                  evt_id;
		logic [7:0]                  len;
		logic [REPLY_BYTES-1:0][7:0] payload;
	} reply_t;

	// Setting registers, reg_id 0 to 3 in this order
	typedef struct packed {
		logic [7:0] uart_baud_div;
		logic [7:0] goc_speed;
		logic [7:0] mbus_clk_div;
		logic [7:0] power_sw;
	} settings_t;

	typedef enum logic [2:0] {
		ST_TYPE,
		ST_EVT,
		ST_LEN,
		ST_PAYLOAD,
		ST_WAIT
	} dec_state_e;

	typedef enum logic [2:0] {
		SR_IDLE,
		SR_KIND,
		SR_EVT,
		SR_LEN,
		SR_DATA
	} ser_state_e;

endpackage

`default_nettype wire

// ==== logic/ice_frame_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module ice_frame_decoder (
	input  wire                clk,
	input  wire                arst_n,
	input  wire  [7:0]         rx_char,
	input  wire                rx_char_valid,
	output logic               rx_char_ready,
	input  wire                reply_done,
	output ice_pkg::ma_bus_t   ma_bus,
	output ice_pkg::ma_frame_t ma_frame,
	output logic               nak_req,
	output ice_pkg::reply_t    nak_reply,
	input  wire                nak_grant
);
	import ice_pkg::*;

	dec_state_e state;
	logic [7:0] type_q;
	logic [7:0] evt_q;
	logic [7:0] len_q;
	logic [7:0] data_q;
	logic [7:0] remain_cnt;
	logic       frame_ok;
	logic       frame_valid;
	logic       data_valid;
	logic       end_stb;
	logic       rx_take;
	logic       type_known;
	logic       hdr_ok;

	// Input held off while a reply is pending
	assign rx_char_ready = (state != ST_WAIT);
	assign rx_take = rx_char_valid & rx_char_ready;

	// Types some responder answers
	always_comb begin
		case (type_q)
			CMD_VERSION, CMD_SET_WRITE, CMD_SET_READ, CMD_GPIO_WRITE, CMD_GPIO_READ:
				type_known = 1'b1;
			default:
				type_known = 1'b0;
		endcase
	end

	// Checked while the length byte is on rx_char
	assign hdr_ok = type_known && (rx_char <= 8'(MAX_PAYLOAD));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_TYPE;
			remain_cnt <= 8'd0;
			frame_ok <= 1'b0;
			frame_valid <= 1'b0;
			data_valid <= 1'b0;
			end_stb <= 1'b0;
			nak_req <= 1'b0;
		end else begin
			data_valid <= 1'b0;
			end_stb <= 1'b0;
			// Frame window closes after the end strobe
			if (end_stb)
				frame_valid <= 1'b0;
			case (state)
				ST_TYPE: begin
					if (rx_take)
						state <= ST_EVT;
				end
				ST_EVT: begin
					if (rx_take)
						state <= ST_LEN;
				end
				ST_LEN: begin
					if (rx_take) begin
						frame_ok <= hdr_ok;
						// Bad frames are consumed but not broadcast
						frame_valid <= hdr_ok;
						remain_cnt <= rx_char;
						if (rx_char == 8'd0) begin
							end_stb <= 1'b1;
							state <= ST_WAIT;
						end else begin
							state <= ST_PAYLOAD;
						end
					end
				end
				ST_PAYLOAD: begin
					if (rx_take) begin
						data_valid <= frame_ok;
						remain_cnt <= remain_cnt - 8'd1;
						if (remain_cnt == 8'd1) begin
							end_stb <= 1'b1;
							state <= ST_WAIT;
						end
					end
				end
				ST_WAIT: begin
					if (reply_done)
						state <= ST_TYPE;
				end
				default: state <= ST_TYPE;
			endcase
			// Immediate NAK for frames nobody will answer
			if (nak_grant)
				nak_req <= 1'b0;
			else if (end_stb && !frame_ok)
				nak_req <= 1'b1;
		end
	end

	// Header and payload capture
	always_ff @(posedge clk) begin
		if (rx_take) begin
			case (state)
				ST_TYPE:    type_q <= rx_char;
				ST_EVT:     evt_q <= rx_char;
				ST_LEN:     len_q <= rx_char;
				ST_PAYLOAD: data_q <= rx_char;
				default:    data_q <= data_q;
			endcase
		end
	end

	assign ma_bus = '{
		frame_valid: frame_valid,
		data_valid:  data_valid,
		addr:        type_q,
		data:        data_q
	};

	assign ma_frame = '{
		evt_id:    evt_q,
		len:       len_q,
		frame_end: end_stb & frame_ok
	};

	// NAK echoes the event id with no payload
	assign nak_reply = '{kind: REPLY_NAK, evt_id: evt_q, len: 8'd0, payload: '0};

	a_dv_in_frame: assert property (@(posedge clk) disable iff (!arst_n)
		ma_bus.data_valid |-> ma_bus.frame_valid);

endmodule

`default_nettype wire

// ==== logic/basics_responder.sv ====
`timescale 1ns/1ps
`default_nettype none

module basics_responder #(
	parameter int VERSION_MAJOR = 2,
	parameter int VERSION_MINOR = 1
) (
	input  wire                clk,
	input  wire                arst_n,
	input  wire ice_pkg::ma_bus_t   ma_bus,
	input  wire ice_pkg::ma_frame_t ma_frame,
	output logic               req,
	output ice_pkg::reply_t    reply,
	input  wire                grant,
	output ice_pkg::settings_t settings
);
	import ice_pkg::*;

	logic       mine;
	logic       decide;
	logic       wr_en;
	logic [1:0] byte_cnt;
	logic [7:0] b0_q;
	logic [7:0] b1_q;
	logic [7:0] arg0;
	logic [7:0] arg1;
	logic [7:0] rd_val;
	reply_t     reply_n;

	// Version and setting commands
	always_comb begin
		case (ma_bus.addr)
			CMD_VERSION, CMD_SET_WRITE, CMD_SET_READ: mine = 1'b1;
			default:                                  mine = 1'b0;
		endcase
	end

	assign decide = ma_frame.frame_end & ma_bus.frame_valid & mine;

	// Last byte can arrive together with frame_end
	always_comb begin
		arg0 = b0_q;
		arg1 = b1_q;
		if (ma_bus.data_valid) begin
			if (byte_cnt == 2'd0)
				arg0 = ma_bus.data;
			if (byte_cnt == 2'd1)
				arg1 = ma_bus.data;
		end
	end

	// Payload byte position, saturates after two
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			byte_cnt <= 2'd0;
		else if (!ma_bus.frame_valid)
			byte_cnt <= 2'd0;
		else if (ma_bus.data_valid && byte_cnt != 2'd2)
			byte_cnt <= byte_cnt + 2'd1;
	end

	always_ff @(posedge clk) begin
		if (mine) begin
			b0_q <= arg0;
			b1_q <= arg1;
		end
	end

	// Register read mux
	always_comb begin
		case (arg0)
			8'd0:    rd_val = settings.uart_baud_div;
			8'd1:    rd_val = settings.goc_speed;
			8'd2:    rd_val = settings.mbus_clk_div;
			8'd3:    rd_val = settings.power_sw;
			default: rd_val = 8'd0;
		endcase
	end

	// NAK unless length and reg_id check out
	always_comb begin
		reply_n = '{kind: REPLY_NAK, evt_id: ma_frame.evt_id, len: 8'd0, payload: '0};
		wr_en = 1'b0;
		case (ma_bus.addr)
			CMD_VERSION: begin
				if (ma_frame.len == 8'd0) begin
					reply_n.kind = REPLY_ACK;
					reply_n.len = 8'd2;
					reply_n.payload[0] = 8'(VERSION_MAJOR);
					reply_n.payload[1] = 8'(VERSION_MINOR);
				end
			end
			CMD_SET_WRITE: begin
				if (ma_frame.len == 8'd2 && arg0 <= 8'd3) begin
					reply_n.kind = REPLY_ACK;
					wr_en = 1'b1;
				end
			end
			CMD_SET_READ: begin
				if (ma_frame.len == 8'd1 && arg0 <= 8'd3) begin
					reply_n.kind = REPLY_ACK;
					reply_n.len = 8'd1;
					reply_n.payload[0] = rd_val;
				end
			end
			default: wr_en = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			req <= 1'b0;
			settings <= '0;
		end else begin
			if (grant)
				req <= 1'b0;
			else if (decide)
				req <= 1'b1;
			if (decide && wr_en) begin
				case (arg0[1:0])
					2'd0: settings.uart_baud_div <= arg1;
					2'd1: settings.goc_speed <= arg1;
					2'd2: settings.mbus_clk_div <= arg1;
					2'd3: settings.power_sw <= arg1;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (decide)
			reply <= reply_n;
	end

	// Descriptor held until the arbiter takes it
	a_reply_hold: assert property (@(posedge clk) disable iff (!arst_n)
		req && !grant |=> req && $stable(reply));

endmodule

`default_nettype wire

// ==== logic/gpio_responder.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpio_responder #(
	parameter int GPIO_WIDTH = 8
) (
	input  wire                     clk,
	input  wire                     arst_n,
	input  wire ice_pkg::ma_bus_t   ma_bus,
	input  wire ice_pkg::ma_frame_t ma_frame,
	output logic                    req,
	output ice_pkg::reply_t         reply,
	input  wire                     grant,
	input  wire  [GPIO_WIDTH-1:0]   gpio_in,
	output logic [GPIO_WIDTH-1:0]   gpio_level,
	output logic [GPIO_WIDTH-1:0]   gpio_oe
);
	import ice_pkg::*;

	logic       mine;
	logic       decide;
	logic       wr_en;
	logic       byte_idx;
	logic [7:0] b0_q;
	logic [7:0] arg0;
	logic [7:0] arg1;
	reply_t     reply_n;

	// Pin commands only
	assign mine = (ma_bus.addr == CMD_GPIO_WRITE) || (ma_bus.addr == CMD_GPIO_READ);
	assign decide = ma_frame.frame_end & ma_bus.frame_valid & mine;

	// Second byte is the one beside frame_end
	assign arg0 = (ma_bus.data_valid && !byte_idx) ? ma_bus.data : b0_q;
	assign arg1 = ma_bus.data;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			byte_idx <= 1'b0;
		else if (!ma_bus.frame_valid)
			byte_idx <= 1'b0;
		else if (ma_bus.data_valid)
			byte_idx <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (mine && ma_bus.data_valid && !byte_idx)
			b0_q <= ma_bus.data;
	end

	always_comb begin
		reply_n = '{kind: REPLY_NAK, evt_id: ma_frame.evt_id, len: 8'd0, payload: '0};
		wr_en = 1'b0;
		if (ma_bus.addr == CMD_GPIO_WRITE && ma_frame.len == 8'd2) begin
			reply_n.kind = REPLY_ACK;
			wr_en = ma_bus.data_valid && byte_idx;
		end else if (ma_bus.addr == CMD_GPIO_READ && ma_frame.len == 8'd0) begin
			// Pins sampled at frame_end
			reply_n.kind = REPLY_ACK;
			reply_n.len = 8'd1;
			reply_n.payload[0] = 8'(gpio_in);
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			req <= 1'b0;
			gpio_level <= '0;
			gpio_oe <= '0;
		end else begin
			if (grant)
				req <= 1'b0;
			else if (decide)
				req <= 1'b1;
			// Level byte first, then direction
			if (decide && wr_en) begin
				gpio_level <= arg0[GPIO_WIDTH-1:0];
				gpio_oe <= arg1[GPIO_WIDTH-1:0];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (decide)
			reply <= reply_n;
	end

endmodule

`default_nettype wire

// ==== logic/ice_reply_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module ice_reply_arbiter (
	input  wire                          clk,
	input  wire                          arst_n,
	input  wire  [ice_pkg::NUM_RESP-1:0] req,
	input  wire ice_pkg::reply_t         replies [ice_pkg::NUM_RESP],
	output logic [ice_pkg::NUM_RESP-1:0] grant,
	output logic [7:0]                   tx_char,
	output logic                         tx_char_valid,
	input  wire                          tx_char_ready,
	output logic                         reply_done
);
	import ice_pkg::*;

	localparam int SEL_W = $clog2(NUM_RESP);
	localparam int IDX_W = $clog2(REPLY_BYTES);

	ser_state_e       state;
	logic [SEL_W-1:0] pick;
	logic [SEL_W-1:0] sel_q;
	logic [NUM_RESP-1:0] pick_oh;
	logic [IDX_W-1:0] byte_idx;
	reply_t           cur;
	logic             tx_take;
	logic             last_data;

	// Fixed priority, lowest index wins
	always_comb begin
		pick = '0;
		pick_oh = '0;
		for (int i = NUM_RESP - 1; i >= 0; i--) begin
			if (req[i]) begin
				pick = SEL_W'(i);
				pick_oh = NUM_RESP'(1) << i;
			end
		end
	end

	assign tx_char_valid = (state != SR_IDLE);
	assign tx_take = tx_char_valid & tx_char_ready;
	assign last_data = (8'(byte_idx) + 8'd1) == cur.len;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= SR_IDLE;
			grant <= '0;
			sel_q <= '0;
			byte_idx <= '0;
			reply_done <= 1'b0;
		end else begin
			grant <= '0;
			reply_done <= 1'b0;
			case (state)
				SR_IDLE: begin
					// Grant cycle, descriptor latched here
					if (grant != '0) begin
						state <= SR_KIND;
					end else if (|req) begin
						grant <= pick_oh;
						sel_q <= pick;
					end
				end
				SR_KIND: begin
					if (tx_take)
						state <= SR_EVT;
				end
				SR_EVT: begin
					if (tx_take)
						state <= SR_LEN;
				end
				SR_LEN: begin
					if (tx_take) begin
						byte_idx <= '0;
						if (cur.len == 8'd0) begin
							reply_done <= 1'b1;
							state <= SR_IDLE;
						end else begin
							state <= SR_DATA;
						end
					end
				end
				SR_DATA: begin
					if (tx_take) begin
						if (last_data) begin
							reply_done <= 1'b1;
							state <= SR_IDLE;
						end else begin
							byte_idx <= byte_idx + 1'b1;
						end
					end
				end
				default: state <= SR_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == SR_IDLE && grant != '0)
			cur <= replies[sel_q];
	end

	// Byte on the line follows the state only
	always_comb begin
		case (state)
			SR_KIND: tx_char = cur.kind;
			SR_EVT:  tx_char = cur.evt_id;
			SR_LEN:  tx_char = cur.len;
			SR_DATA: tx_char = cur.payload[byte_idx];
			default: tx_char = 8'd0;
		endcase
	end

	a_grant_legal: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0(grant) && ((grant & ~req) == '0));

	// Stall keeps the same byte on the line
	a_stall_hold: assert property (@(posedge clk) disable iff (!arst_n)
		tx_char_valid && !tx_char_ready |=> tx_char_valid && $stable(tx_char));

endmodule

`default_nettype wire

// ==== logic/ice_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

module ice_bus #(
	parameter int VERSION_MAJOR = 2,
	parameter int VERSION_MINOR = 1,
	parameter int GPIO_WIDTH = 8
) (
	input  wire                     clk,
	input  wire                     arst_n,
	input  wire  [7:0]              rx_char,
	input  wire                     rx_char_valid,
	output logic                    rx_char_ready,
	output logic [7:0]              tx_char,
	output logic                    tx_char_valid,
	input  wire                     tx_char_ready,
	input  wire  [GPIO_WIDTH-1:0]   gpio_in,
	output logic [GPIO_WIDTH-1:0]   gpio_level,
	output logic [GPIO_WIDTH-1:0]   gpio_oe,
	output ice_pkg::settings_t      settings
);
	import ice_pkg::*;

	// Master bus and frame header
	ma_bus_t              ma_bus;
	ma_frame_t            ma_frame;
	// Request/grant per responder, index 0 is the immediate NAK
	wire [NUM_RESP-1:0]   req;
	logic [NUM_RESP-1:0]  grant;
	wire reply_t          replies [NUM_RESP];
	logic                 reply_done;

	ice_frame_decoder u_decoder (
		.clk(clk),
		.arst_n(arst_n),
		.rx_char(rx_char),
		.rx_char_valid(rx_char_valid),
		.rx_char_ready(rx_char_ready),
		.reply_done(reply_done),
		.ma_bus(ma_bus),
		.ma_frame(ma_frame),
		.nak_req(req[0]),
		.nak_reply(replies[0]),
		.nak_grant(grant[0])
	);

	// Version and setting registers
	basics_responder #(
		.VERSION_MAJOR(VERSION_MAJOR),
		.VERSION_MINOR(VERSION_MINOR)
	) u_basics (
		.clk(clk),
		.arst_n(arst_n),
		.ma_bus(ma_bus),
		.ma_frame(ma_frame),
		.req(req[1]),
		.reply(replies[1]),
		.grant(grant[1]),
		.settings(settings)
	);

	// Pin access
	gpio_responder #(
		.GPIO_WIDTH(GPIO_WIDTH)
	) u_gpio (
		.clk(clk),
		.arst_n(arst_n),
		.ma_bus(ma_bus),
		.ma_frame(ma_frame),
		.req(req[2]),
		.reply(replies[2]),
		.grant(grant[2]),
		.gpio_in(gpio_in),
		.gpio_level(gpio_level),
		.gpio_oe(gpio_oe)
	);

	ice_reply_arbiter u_arbiter (
		.clk(clk),
		.arst_n(arst_n),
		.req(req),
		.replies(replies),
		.grant(grant),
		.tx_char(tx_char),
		.tx_char_valid(tx_char_valid),
		.tx_char_ready(tx_char_ready),
		.reply_done(reply_done)
	);

endmodule

`default_nettype wire

// ==== tests/tb_ice_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ice_bus;
	import ice_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int NUM_FRAMES = 22;
	// Golden line columns
	localparam int LINE_W = 26;
	localparam int FRAME_COL = 1;
	localparam int FRAME_MAX = 12;
	localparam int REPLY_COL = 13;
	localparam int SET_COL = 20;
	localparam int PIN_COL = 24;
	// Header, full payload and longest reply, 20 cycles per byte
	localparam int TIMEOUT_NS = (16 + NUM_FRAMES * (3 + 8 + 7) * 20) * CLK_PERIOD;

	logic       clk;
	logic       arst_n;
	logic [7:0] rx_char;
	logic       rx_char_valid;
	logic       rx_char_ready;
	logic [7:0] tx_char;
	logic       tx_char_valid;
	logic       tx_char_ready;
	logic [7:0] gpio_in;
	logic [7:0] gpio_level;
	logic [7:0] gpio_oe;
	settings_t  settings;

	logic [7:0] golden [NUM_FRAMES*LINE_W];
	integer     seed;
	int         line_no;

	ice_bus u_ice_bus (
		.clk(clk),
		.arst_n(arst_n),
		.rx_char(rx_char),
		.rx_char_valid(rx_char_valid),
		.rx_char_ready(rx_char_ready),
		.tx_char(tx_char),
		.tx_char_valid(tx_char_valid),
		.tx_char_ready(tx_char_ready),
		.gpio_in(gpio_in),
		.gpio_level(gpio_level),
		.gpio_oe(gpio_oe),
		.settings(settings)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("Mismatch at %0t ns: %s, got %0h, expected %0h", $time, what, actual,
				expected);
			$display("TEST FAILED");
			$fatal(1, "value check failed");
		end
	endtask

	// Everything on the TB side happens 1 ns after the edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	// Byte stays on the line until the decoder takes it
	task automatic send_byte(input logic [7:0] b);
		logic taken;
		begin
			rx_char = b;
			rx_char_valid = 1'b1;
			taken = 1'b0;
			while (!taken) begin
				taken = rx_char_ready;
				next_cycle();
			end
		end
	endtask

	// Reply runs until the decoder reopens its input
	task automatic collect_reply(input int base);
		int n_exp;
		int n_got;
		begin
			n_exp = 3 + int'(golden[base + REPLY_COL + 2]);
			n_got = 0;
			while (!rx_char_ready) begin
				// About 30% stall
				tx_char_ready = (($unsigned($random(seed)) % 10) >= 3);
				if (tx_char_valid && tx_char_ready) begin
					check_value(32'(n_got < n_exp), 32'd1,
						$sformatf("line %0d extra reply byte %0d", line_no, n_got));
					check_value(32'(tx_char), 32'(golden[base + REPLY_COL + n_got]),
						$sformatf("line %0d reply byte %0d", line_no, n_got));
					n_got++;
				end
				next_cycle();
			end
			tx_char_ready = 1'b0;
			check_value(32'(n_got), 32'(n_exp), $sformatf("line %0d reply length", line_no));
		end
	endtask

	// No reply byte while frame input is open
	initial begin
		wait (arst_n === 1'b1);
		forever begin
			next_cycle();
			if (tx_char_valid)
				check_value(32'(rx_char_ready), 32'd0, "rx_char_ready high during a reply");
		end
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Watchdog expired after %0d ns, the DUT stopped responding", TIMEOUT_NS);
		$display("TEST FAILED");
		$fatal(1, "watchdog timeout");
	end

	initial begin
		int base;
		int n_frame;
		clk = 1'b0;
		arst_n = 1'b0;
		rx_char = 8'd0;
		rx_char_valid = 1'b0;
		tx_char_ready = 1'b0;
		gpio_in = 8'd0;
		seed = 32'h99ac_2272;
		$readmemh("tests/ice_bus_golden.txt", golden);
		if ($isunknown(golden[FRAME_COL]) || golden[FRAME_COL] == 8'h00) begin
			$display("Golden file tests/ice_bus_golden.txt is missing or empty");
			$display("TEST FAILED");
			$fatal(1, "no stimulus");
		end
		repeat (16) @(posedge clk);
		#1;
		arst_n = 1'b1;
		// Reset state
		check_value(32'(rx_char_ready), 32'd1, "rx_char_ready after reset");
		check_value(32'(tx_char_valid), 32'd0, "tx_char_valid after reset");
		check_value(32'(gpio_oe), 32'd0, "gpio_oe after reset");
		check_value(32'(settings), 32'd0, "settings after reset");
		next_cycle();
		for (line_no = 0; line_no < NUM_FRAMES; line_no++) begin
			base = line_no * LINE_W;
			gpio_in = golden[base];
			// Header plus declared length
			n_frame = 3 + int'(golden[base + FRAME_COL + 2]);
			check_value(32'(n_frame <= FRAME_MAX), 32'd1,
				$sformatf("line %0d frame fits the golden columns", line_no));
			for (int i = 0; i < n_frame; i++)
				send_byte(golden[base + FRAME_COL + i]);
			rx_char_valid = 1'b0;
			// Held off from the cycle after the last byte
			check_value(32'(rx_char_ready), 32'd0,
				$sformatf("line %0d rx_char_ready after frame", line_no));
			collect_reply(base);
			check_value(32'(settings.uart_baud_div), 32'(golden[base + SET_COL]),
				$sformatf("line %0d uart_baud_div", line_no));
			check_value(32'(settings.goc_speed), 32'(golden[base + SET_COL + 1]),
				$sformatf("line %0d goc_speed", line_no));
			check_value(32'(settings.mbus_clk_div), 32'(golden[base + SET_COL + 2]),
				$sformatf("line %0d mbus_clk_div", line_no));
			check_value(32'(settings.power_sw), 32'(golden[base + SET_COL + 3]),
				$sformatf("line %0d power_sw", line_no));
			check_value(32'(gpio_level), 32'(golden[base + PIN_COL]),
				$sformatf("line %0d gpio_level", line_no));
			check_value(32'(gpio_oe), 32'(golden[base + PIN_COL + 1]),
				$sformatf("line %0d gpio_oe", line_no));
		end
		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/ice_bus_golden.txt ====
// gpio_in  frame bytes (type evt len payload, 12 cols)  reply bytes (7 cols)
// settings (uart goc mbus power)  gpio_level gpio_oe, all hex, unused cols 00
a5  56 01 00 00 00 00 00 00 00 00 00 00  00 01 02 02 01 00 00  00 00 00 00  00 00
a5  53 02 02 00 1b 00 00 00 00 00 00 00  00 02 00 00 00 00 00  1b 00 00 00  00 00
a5  53 03 02 03 c4 00 00 00 00 00 00 00  00 03 00 00 00 00 00  1b 00 00 c4  00 00
a5  73 04 01 00 00 00 00 00 00 00 00 00  00 04 01 1b 00 00 00  1b 00 00 c4  00 00
a5  73 05 01 03 00 00 00 00 00 00 00 00  00 05 01 c4 00 00 00  1b 00 00 c4  00 00
a5  53 06 02 04 77 00 00 00 00 00 00 00  01 06 00 00 00 00 00  1b 00 00 c4  00 00
a5  73 07 01 04 00 00 00 00 00 00 00 00  01 07 00 00 00 00 00  1b 00 00 c4  00 00
a5  53 08 02 02 5e 00 00 00 00 00 00 00  00 08 00 00 00 00 00  1b 00 5e c4  00 00
a5  73 09 01 02 00 00 00 00 00 00 00 00  00 09 01 5e 00 00 00  1b 00 5e c4  00 00
a5  47 10 02 3c f0 00 00 00 00 00 00 00  00 10 00 00 00 00 00  1b 00 5e c4  3c f0
96  67 11 00 00 00 00 00 00 00 00 00 00  00 11 01 96 00 00 00  1b 00 5e c4  3c f0
5a  67 12 00 00 00 00 00 00 00 00 00 00  00 12 01 5a 00 00 00  1b 00 5e c4  3c f0
5a  58 13 00 00 00 00 00 00 00 00 00 00  01 13 00 00 00 00 00  1b 00 5e c4  3c f0
5a  71 14 02 aa bb 00 00 00 00 00 00 00  01 14 00 00 00 00 00  1b 00 5e c4  3c f0
5a  56 15 09 01 02 03 04 05 06 07 08 09  01 15 00 00 00 00 00  1b 00 5e c4  3c f0
5a  56 16 01 00 00 00 00 00 00 00 00 00  01 16 00 00 00 00 00  1b 00 5e c4  3c f0
5a  67 17 01 55 00 00 00 00 00 00 00 00  01 17 00 00 00 00 00  1b 00 5e c4  3c f0
5a  47 18 01 ff 00 00 00 00 00 00 00 00  01 18 00 00 00 00 00  1b 00 5e c4  3c f0
5a  53 19 01 01 00 00 00 00 00 00 00 00  01 19 00 00 00 00 00  1b 00 5e c4  3c f0
5a  53 20 02 01 99 00 00 00 00 00 00 00  00 20 00 00 00 00 00  1b 99 5e c4  3c f0
5a  47 21 02 81 0f 00 00 00 00 00 00 00  00 21 00 00 00 00 00  1b 99 5e c4  81 0f
5a  56 22 00 00 00 00 00 00 00 00 00 00  00 22 02 02 01 00 00  1b 99 5e c4  81 0f

// ==== vlog.f ====
logic/ice_pkg.sv
logic/ice_frame_decoder.sv
logic/basics_responder.sv
logic/gpio_responder.sv
logic/ice_reply_arbiter.sv
logic/ice_bus.sv
tests/tb_ice_bus.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run tb_ice_bus with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
	--top-module tb_ice_bus -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_ice_bus
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

echo "Simulation finished"
exit 0
